// ==== src/vec_pkg.sv ====
// Vector coprocessor package
// Sizes, opcodes and the packed structs shared by every block

`default_nettype none

package vec_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned ElemWidth      = 16;
  localparam int unsigned NrLanes        = 4;
  localparam int unsigned NrVRegs        = 8;
  localparam int unsigned VlenElems      = 8;
  // Also the number of execution cycles per instruction
  localparam int unsigned ElemsPerLane   = VlenElems / NrLanes;
  localparam int unsigned InsnQueueDepth = 4;
  localparam int unsigned RespQueueDepth = 2;

  typedef logic [ElemWidth-1:0]            elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]      vreg_idx_t;
  typedef logic [$clog2(VlenElems)-1:0]    elem_idx_t;
  typedef logic [$clog2(ElemsPerLane)-1:0] slot_idx_t;
  typedef logic [$clog2(NrLanes)-1:0]      lane_idx_t;

  //////////////////////////////
  // Opcodes and payloads
  //////////////////////////////

  // Encodings 8 to 15 are all treated as illegal
  typedef enum logic [3:0] {
    VADD     = 4'd0,
    VSUB     = 4'd1,
    VAND     = 4'd2,
    VOR      = 4'd3,
    VXOR     = 4'd4,
    VMV_VX   = 4'd5,
    VMV_XS   = 4'd6,
    VID_VX   = 4'd7,
    VILLEGAL = 4'd15
  } vop_e;

  // Host instruction word, top bit first
  typedef struct packed {
    logic [3:0] opcode;
    vreg_idx_t  vd;
    vreg_idx_t  vs1;
    vreg_idx_t  vs2;
    elem_idx_t  idx;
  } insn_word_t;

  typedef struct packed {
    insn_word_t insn;
    elem_t      scalar;
  } acc_req_t;

  typedef struct packed {
    elem_t data;
    logic  illegal;
  } acc_resp_t;

  // Decoded instruction, as held in the instruction queue
  typedef struct packed {
    vop_e      op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_idx_t idx;
    elem_t     scalar;
  } vinsn_t;

  // Broadcast to every lane once per cycle
  typedef struct packed {
    vop_e      op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    slot_idx_t slot;
    elem_t     scalar;
    logic      we;
  } lane_cmd_t;

endpackage : vec_pkg

`default_nettype wire

// ==== src/vec_dispatcher.sv ====
// Vector instruction dispatcher
// Splits the host instruction word into fields, flags illegal opcodes
// and holds the decoded instruction in a one-entry output register

`timescale 1ns/10ps
`default_nettype none

module vec_dispatcher (
  // Clock and reset
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Host request
  input  vec_pkg::acc_req_t acc_req_i,
  input  logic              acc_req_valid_i,
  output logic              acc_req_ready_o,
  // Towards the instruction queue
  output vec_pkg::vinsn_t   vinsn_o,
  output logic              vinsn_valid_o,
  input  logic              vinsn_ready_i
);

  import vec_pkg::*;

  vinsn_t decoded;
  logic   accept;

  //////////////////////////////
  // Decode
  //////////////////////////////

  always_comb begin
    // Top opcode bit set means one of the unused encodings
    if (acc_req_i.insn.opcode[3]) begin
      decoded.op = VILLEGAL;
    end else begin
      decoded.op = vop_e'(acc_req_i.insn.opcode);
    end
    decoded.vd     = acc_req_i.insn.vd;
    decoded.vs1    = acc_req_i.insn.vs1;
    decoded.vs2    = acc_req_i.insn.vs2;
    decoded.idx    = acc_req_i.insn.idx;
    decoded.scalar = acc_req_i.scalar;
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  // Free when empty or drained in this same cycle
  assign acc_req_ready_o = !vinsn_valid_o || vinsn_ready_i;
  assign accept          = acc_req_valid_i && acc_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vinsn_valid_o <= 1'b0;
    end else if (accept) begin
      vinsn_valid_o <= 1'b1;
    end else if (vinsn_ready_i) begin
      vinsn_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      vinsn_o <= decoded;
    end
  end

  // Held instruction must not move under back-pressure
  a_vinsn_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    vinsn_valid_o && !vinsn_ready_i |=> vinsn_valid_o && $stable(vinsn_o)
  );

endmodule : vec_dispatcher

`default_nettype wire

// ==== src/vec_fifo.sv ====
// Valid/ready FIFO with a generic payload
// Circular buffer without fall-through, a full FIFO takes a push
// only when the same cycle pops

`timescale 1ns/10ps
`default_nettype none

module vec_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Write side
  input  payload_t push_data_i,
  input  logic     push_valid_i,
  output logic     push_ready_o,
  // Read side
  output payload_t pop_data_o,
  output logic     pop_valid_o,
  input  logic     pop_ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);
  localparam logic [CntWidth-1:0] Full    = CntWidth'(Depth);

  payload_t            mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push_ready_o = (count_q != Full) || pop_ready_i;

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  // Pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  a_count_bound : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) count_q <= Full
  );

endmodule : vec_fifo

`default_nettype wire

// ==== src/vec_lane.sv ====
// Vector lane
// Holds one lane's slice of the vector register file and computes
// one element per cycle for the broadcast command

`timescale 1ns/10ps
`default_nettype none

module vec_lane #(
  parameter int unsigned LaneId = 0
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  vec_pkg::lane_cmd_t cmd_i,
  // vs2 at the current slot
  output vec_pkg::elem_t     read_elem_o
);

  import vec_pkg::*;

  // Slot s of this lane holds element s * NrLanes + LaneId
  elem_t     vrf_q [NrVRegs][ElemsPerLane];
  elem_t     op_a;
  elem_t     op_b;
  elem_t     result;
  elem_idx_t elem_idx;

  assign op_a        = vrf_q[cmd_i.vs1][cmd_i.slot];
  assign op_b        = vrf_q[cmd_i.vs2][cmd_i.slot];
  assign read_elem_o = op_b;
  assign elem_idx    = elem_idx_t'(cmd_i.slot * NrLanes + LaneId);

  //////////////////////////////
  // Element ALU
  //////////////////////////////

  always_comb begin
    case (cmd_i.op)
      VADD:    result = op_a + op_b;
      VSUB:    result = op_a - op_b;
      VAND:    result = op_a & op_b;
      VOR:     result = op_a | op_b;
      VXOR:    result = op_a ^ op_b;
      VMV_VX:  result = cmd_i.scalar;
      // Wraps at the element width
      VID_VX:  result = cmd_i.scalar + ElemWidth'(elem_idx);
      default: result = '0;
    endcase
  end

  //////////////////////////////
  // Register file slice
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < NrVRegs; r++) begin
        for (int s = 0; s < ElemsPerLane; s++) begin
          vrf_q[r][s] <= '0;
        end
      end
    end else if (cmd_i.we) begin
      vrf_q[cmd_i.vd][cmd_i.slot] <= result;
    end
  end

endmodule : vec_lane

`default_nettype wire

// ==== src/vec_lane_array.sv ====
// Vector lane array
// Steps each instruction over the slots of all lanes, one slot per cycle,
// and builds the response for scalar moves and illegal instructions

`timescale 1ns/10ps
`default_nettype none

module vec_lane_array (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // From the instruction queue
  input  vec_pkg::vinsn_t    vinsn_i,
  input  logic               vinsn_valid_i,
  output logic               vinsn_ready_o,
  // To the response queue
  output vec_pkg::acc_resp_t resp_o,
  output logic               resp_valid_o,
  input  logic               resp_ready_i
);

  import vec_pkg::*;

  vinsn_t    insn_q;
  logic      busy_q;
  slot_idx_t slot_q;
  elem_t     capt_q;

  lane_cmd_t lane_cmd;
  elem_t     lane_rd [NrLanes];
  lane_idx_t sel_lane;
  slot_idx_t sel_slot;
  logic      last_slot;
  logic      needs_resp;
  logic      stall;
  logic      finish;
  logic      take;

  //////////////////////////////
  // Sequencing
  //////////////////////////////

  assign needs_resp = insn_q.op inside {VMV_XS, VILLEGAL};
  assign last_slot  = (slot_q == slot_idx_t'(ElemsPerLane - 1));
  assign stall      = resp_valid_o && !resp_ready_i;
  assign finish     = busy_q && last_slot && !stall;

  // Next instruction enters on the edge that retires the current one
  assign vinsn_ready_o = !busy_q || finish;
  assign take          = vinsn_valid_i && vinsn_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      slot_q <= '0;
    end else if (take) begin
      busy_q <= 1'b1;
      slot_q <= '0;
    end else if (finish) begin
      busy_q <= 1'b0;
    end else if (busy_q && !last_slot) begin
      slot_q <= slot_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      insn_q <= vinsn_i;
    end
  end

  //////////////////////////////
  // Lanes
  //////////////////////////////

  always_comb begin
    lane_cmd.op     = insn_q.op;
    lane_cmd.vd     = insn_q.vd;
    lane_cmd.vs1    = insn_q.vs1;
    lane_cmd.vs2    = insn_q.vs2;
    lane_cmd.slot   = slot_q;
    lane_cmd.scalar = insn_q.scalar;
    lane_cmd.we     = busy_q && !needs_resp && !stall;
  end

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .LaneId(l)
    ) i_lane (
      .clk_i      (clk_i     ),
      .rst_n_i    (rst_n_i   ),
      .cmd_i      (lane_cmd  ),
      .read_elem_o(lane_rd[l])
    );
  end : gen_lanes

  //////////////////////////////
  // Response
  //////////////////////////////

  // Element e sits in lane e mod NrLanes, slot e div NrLanes
  assign sel_lane = lane_idx_t'(insn_q.idx);
  assign sel_slot = slot_idx_t'(insn_q.idx >> $bits(lane_idx_t));

  always_ff @(posedge clk_i) begin
    if (busy_q && (sel_slot == slot_q)) begin
      capt_q <= lane_rd[sel_lane];
    end
  end

  assign resp_valid_o = busy_q && last_slot && needs_resp;

  always_comb begin
    resp_o.illegal = (insn_q.op == VILLEGAL);
    if (insn_q.op == VILLEGAL) begin
      resp_o.data = '0;
    end else if (sel_slot == slot_q) begin
      // requested element in the final slot is read directly
      resp_o.data = lane_rd[sel_lane];
    end else begin
      resp_o.data = capt_q;
    end
  end

  // Every instruction occupies the lanes for all its slots
  a_no_overlap : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    take |=> !take [*(ElemsPerLane - 1)]
  );

  a_resp_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o)
  );

endmodule : vec_lane_array

`default_nettype wire

// ==== src/vec_top.sv ====
// Vector coprocessor top level
// Dispatcher, instruction queue, lane array and response queue in a chain

`timescale 1ns/10ps
`default_nettype none

module vec_top (
  // Clock and reset
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Host request
  input  vec_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  // Host response
  output vec_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i
);

  import vec_pkg::*;

  //////////////////////////////
  // Dispatcher
  //////////////////////////////

  vinsn_t disp_vinsn;
  logic   disp_valid;
  logic   disp_ready;

  vec_dispatcher i_dispatcher (
    .clk_i          (clk_i          ),
    .rst_n_i        (rst_n_i        ),
    .acc_req_i      (acc_req_i      ),
    .acc_req_valid_i(acc_req_valid_i),
    .acc_req_ready_o(acc_req_ready_o),
    .vinsn_o        (disp_vinsn     ),
    .vinsn_valid_o  (disp_valid     ),
    .vinsn_ready_i  (disp_ready     )
  );

  // Decoded instructions waiting for the lanes
  vinsn_t head_vinsn;
  logic   head_valid;
  logic   head_ready;

  vec_fifo #(
    .payload_t(vinsn_t       ),
    .Depth    (InsnQueueDepth)
  ) i_insn_queue (
    .clk_i       (clk_i     ),
    .rst_n_i     (rst_n_i   ),
    .push_data_i (disp_vinsn),
    .push_valid_i(disp_valid),
    .push_ready_o(disp_ready),
    .pop_data_o  (head_vinsn),
    .pop_valid_o (head_valid),
    .pop_ready_i (head_ready)
  );

  //////////////////////////////
  // Lanes and responses
  //////////////////////////////

  acc_resp_t lane_resp;
  logic      lane_resp_valid;
  logic      lane_resp_ready;

  vec_lane_array i_lane_array (
    .clk_i        (clk_i          ),
    .rst_n_i      (rst_n_i        ),
    .vinsn_i      (head_vinsn     ),
    .vinsn_valid_i(head_valid     ),
    .vinsn_ready_o(head_ready     ),
    .resp_o       (lane_resp      ),
    .resp_valid_o (lane_resp_valid),
    .resp_ready_i (lane_resp_ready)
  );

  vec_fifo #(
    .payload_t(acc_resp_t    ),
    .Depth    (RespQueueDepth)
  ) i_resp_queue (
    .clk_i       (clk_i           ),
    .rst_n_i     (rst_n_i         ),
    .push_data_i (lane_resp       ),
    .push_valid_i(lane_resp_valid ),
    .push_ready_o(lane_resp_ready ),
    .pop_data_o  (acc_resp_o      ),
    .pop_valid_o (acc_resp_valid_o),
    .pop_ready_i (acc_resp_ready_i)
  );

endmodule : vec_top

`default_nettype wire

// ==== sim/tb_vec_top.sv ====
// Vector coprocessor testbench
// Issues directed and random instructions, mirrors them in a reference
// register file and checks every response with assertions

`timescale 1ns/10ps
`default_nettype none

module tb_vec_top;

  import vec_pkg::*;

  localparam int ClkPeriod      = 4;
  localparam int NumRegReads    = NrVRegs * VlenElems;
  localparam int NumRandom      = 80;
  localparam int NumIllegal     = 8;
  localparam int NumStress      = 60;
  localparam int TotalInsns     = 2 * NumRegReads + 2 * (1 + VlenElems) + NumRandom
                                  + NumIllegal + NumStress;
  localparam int WatchdogCycles = TotalInsns * 20 + 200;

  logic      clk_i;
  logic      rst_n_i;
  acc_req_t  acc_req_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  acc_resp_t acc_resp_o;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;
  logic      resp_fire;

  integer    seed;
  elem_t     ref_vrf [NrVRegs][VlenElems];
  acc_resp_t exp_q [$];
  acc_resp_t exp_head;
  int        exp_count;
  int        checked_count;
  int        mismatch_count;
  int        unexpected_count;
  int        missing_count;
  int        other_count;
  logic      saw_req_stall;
  logic      stress_done;
  acc_req_t  stress_req [NumStress];

  vec_top dut0 (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .acc_req_i       (acc_req_i       ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_resp_o      (acc_resp_o      ),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  assign resp_fire = acc_resp_valid_o && acc_resp_ready_i;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic void refresh_head();
    exp_count = exp_q.size();
    exp_head  = (exp_q.size() > 0) ? exp_q[0] : '0;
  endfunction

  function automatic elem_t binary_result(input logic [3:0] opcode, input elem_t a,
                                          input elem_t b);
    case (opcode)
      VADD:    return a + b;
      VSUB:    return a - b;
      VAND:    return a & b;
      VOR:     return a | b;
      default: return a ^ b;
    endcase
  endfunction

  // Updated at issue time since execution is in order
  function automatic void apply_to_model(input acc_req_t req);
    insn_word_t w;
    acc_resp_t  resp;
    w    = req.insn;
    resp = '0;
    if (w.opcode >= 4'd8) begin
      resp.illegal = 1'b1;
      exp_q.push_back(resp);
    end else begin
      case (w.opcode)
        VMV_XS: begin
          resp.data = ref_vrf[w.vs2][w.idx];
          exp_q.push_back(resp);
        end
        VMV_VX: begin
          for (int e = 0; e < VlenElems; e++) begin
            ref_vrf[w.vd][e] = req.scalar;
          end
        end
        VID_VX: begin
          for (int e = 0; e < VlenElems; e++) begin
            ref_vrf[w.vd][e] = req.scalar + elem_t'(e);
          end
        end
        default: begin
          for (int e = 0; e < VlenElems; e++) begin
            ref_vrf[w.vd][e] = binary_result(w.opcode, ref_vrf[w.vs1][e], ref_vrf[w.vs2][e]);
          end
        end
      endcase
    end
    refresh_head();
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Any legal opcode with random fields
  function automatic acc_req_t random_req();
    acc_req_t req;
    req = acc_req_t'($random(seed));
    req.insn.opcode[3] = 1'b0;
    return req;
  endfunction

  function automatic acc_req_t read_req(input vreg_idx_t vs2, input elem_idx_t idx);
    acc_req_t req;
    req = acc_req_t'($random(seed));
    req.insn.opcode = VMV_XS;
    req.insn.vs2    = vs2;
    req.insn.idx    = idx;
    return req;
  endfunction

  // Starts on a falling edge and returns on the falling edge after the transfer
  task automatic issue(input acc_req_t req);
    apply_to_model(req);
    acc_req_i       = req;
    acc_req_valid_i = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!acc_req_ready_o);
    @(negedge clk_i);
    acc_req_valid_i = 1'b0;
  endtask

  task automatic read_all_regs();
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < VlenElems; e++) begin
        issue(read_req(vreg_idx_t'(r), elem_idx_t'(e)));
      end
    end
  endtask

  function automatic void report_counts();
    $display("Responses checked %0d, mismatched %0d, unexpected %0d, missing %0d, other %0d",
             checked_count, mismatch_count, unexpected_count, missing_count, other_count);
  endfunction

  //////////////////////////////
  // Monitors and assertions
  //////////////////////////////

  always @(posedge clk_i) begin
    if (rst_n_i && resp_fire) begin
      checked_count++;
      if (exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      refresh_head();
    end
    // Request port blocked while the host refuses responses
    if (rst_n_i && acc_req_valid_i && !acc_req_ready_o && !acc_resp_ready_i) begin
      saw_req_stall = 1'b1;
    end
  end

  a_quiet_in_reset : assert property (
    @(posedge clk_i) !rst_n_i |-> !acc_resp_valid_o
  ) else begin
    other_count++;
    $display("Response valid was high while reset was asserted");
  end

  a_resp_expected : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) resp_fire |-> exp_count != 0
  ) else begin
    unexpected_count++;
    $display("Response %h arrived with no instruction waiting for it", $sampled(acc_resp_o));
  end

  a_resp_value : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    resp_fire && exp_count != 0 |-> acc_resp_o == exp_head
  ) else begin
    mismatch_count++;
    $display("CHECK FAILED acc_resp_o expected %h actual %h",
             $sampled(exp_head), $sampled(acc_resp_o));
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    acc_req_t  req;
    vreg_idx_t vd;
    elem_idx_t idx;
    int        len;

    seed             = 5177;
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b1;
    checked_count    = 0;
    mismatch_count   = 0;
    unexpected_count = 0;
    missing_count    = 0;
    other_count      = 0;
    saw_req_stall    = 1'b0;
    stress_done      = 1'b0;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < VlenElems; e++) ref_vrf[r][e] = '0;
    end
    refresh_head();

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Every register reads zero after reset
    read_all_regs();

    // Broadcast then read each element
    vd  = vreg_idx_t'($random(seed));
    req = random_req();
    req.insn.opcode = VMV_VX;
    req.insn.vd     = vd;
    issue(req);
    for (int e = 0; e < VlenElems; e++) issue(read_req(vd, elem_idx_t'(e)));

    // Index plus scalar with the scalar near the top so the sum wraps
    vd  = vreg_idx_t'($random(seed));
    req = random_req();
    req.insn.opcode = VID_VX;
    req.insn.vd     = vd;
    req.scalar      = req.scalar | 16'hfffc;
    issue(req);
    for (int e = 0; e < VlenElems; e++) issue(read_req(vd, elem_idx_t'(e)));

    // Random operations with reads in between
    repeat (NumRandom / 2) begin
      issue(random_req());
      vd  = vreg_idx_t'($random(seed));
      idx = elem_idx_t'($random(seed));
      issue(read_req(vd, idx));
    end

    // Illegal encodings must leave the registers untouched
    for (int i = 0; i < NumIllegal; i++) begin
      req = random_req();
      req.insn.opcode = 4'(8 + i);
      issue(req);
    end
    read_all_regs();

    // Response back-pressure in random stretches
    for (int i = 0; i < NumStress; i++) begin
      vd  = vreg_idx_t'($random(seed));
      idx = elem_idx_t'($random(seed));
      stress_req[i] = (i % 2 == 0) ? random_req() : read_req(vd, idx);
    end
    saw_req_stall = 1'b0;
    fork
      begin
        for (int i = 0; i < NumStress; i++) issue(stress_req[i]);
        stress_done = 1'b1;
      end
      begin
        while (!stress_done) begin
          acc_resp_ready_i = 1'b0;
          len = 12 + int'($unsigned($random(seed)) % 16);
          repeat (len) @(negedge clk_i);
          acc_resp_ready_i = 1'b1;
          len = 1 + int'($unsigned($random(seed)) % 4);
          repeat (len) @(negedge clk_i);
        end
        acc_resp_ready_i = 1'b1;
      end
    join
    assert (saw_req_stall) else begin
      other_count++;
      $display("Request port never stalled while responses were held back");
    end

    // Drain outstanding responses
    len = 0;
    while (exp_count != 0 && len < 200) begin
      @(negedge clk_i);
      len++;
    end
    assert (exp_count == 0) else begin
      missing_count += exp_count;
      $display("%0d expected responses never arrived", exp_count);
    end
    repeat (4) @(negedge clk_i);

    report_counts();
    if (mismatch_count + unexpected_count + missing_count + other_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the instruction count
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout, the run did not finish within %0d cycles", WatchdogCycles);
    report_counts();
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule : tb_vec_top

`default_nettype wire

// ==== vlog.f ====
src/vec_pkg.sv
src/vec_dispatcher.sv
src/vec_fifo.sv
src/vec_lane.sv
src/vec_lane_array.sv
src/vec_top.sv
sim/tb_vec_top.sv
